/* action_table.sv */
`timescale 1ns/10ps

module action_table (
    input  logic                                clk,
    input  logic                                aresetn,
    input  logic [deparse_pkg::data_w-1:0]      c_tdata,
    input  logic                                c_tvalid,
    input  logic                                c_tlast,
    input  logic [deparse_pkg::addr_w-1:0]      lookup_addr,
    input  logic                                lookup_en,
    output deparse_pkg::entry_t                 entry
);

    typedef enum logic {
        C_IDLE,
        C_WRITE
    } c_state_t;

    c_state_t                        c_state;
    ctrl_pkg::ctrl_beat_u            c_beat;
    logic                            hdr_hit;
    logic [deparse_pkg::addr_w-1:0]  c_index;
    logic                            c_wr_en;
    logic [deparse_pkg::addr_w-1:0]  c_wr_addr;
    deparse_pkg::entry_t             c_wr_data;
    deparse_pkg::entry_t             act_tbl [deparse_pkg::n_entry];

    assign c_beat = c_tdata;

    // control header addressed to this block
    assign hdr_hit = c_tvalid
                  && c_beat.hdr.mod_id[2:0] == ctrl_pkg::deparser_id
                  && c_beat.hdr.flag == ctrl_pkg::ctrl_flag;

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            c_state   <= C_IDLE;
            c_index   <= '0;
            c_wr_en   <= 1'b0;
            c_wr_addr <= '0;
        end else begin
            c_wr_en <= 1'b0;
            case (c_state)
                C_IDLE: begin
                    // header with tlast carries no entries
                    if (hdr_hit && !c_tlast) begin
                        c_index <= c_beat.hdr.start_idx[deparse_pkg::addr_w-1:0];
                        c_state <= C_WRITE;
                    end
                end
                C_WRITE: begin
                    if (c_tvalid) begin
                        c_wr_en   <= 1'b1;
                        c_wr_addr <= c_index;
                        c_index   <= c_index + 1'b1;
                        if (c_tlast) begin
                            c_state <= C_IDLE;
                        end
                    end
                end
                default: c_state <= C_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (c_state == C_WRITE && c_tvalid) begin
            c_wr_data <= c_beat.ent.ent;
        end
    end

    // write lands one cycle after its control beat
    always_ff @(posedge clk) begin
        if (c_wr_en) begin
            act_tbl[c_wr_addr] <= c_wr_data;
        end
        if (lookup_en) begin
            entry <= act_tbl[lookup_addr];
        end
    end

endmodule

/* container_select.sv */
`timescale 1ns/10ps

module container_select (
    input  logic                              clk,
    input  logic                              aresetn,
    input  deparse_pkg::entry_t               entry,
    input  logic                              entry_valid,
    input  logic [deparse_pkg::phv_w-1:0]     phv,
    edit_if.src                               edit
);

    logic [deparse_pkg::n_act-1:0][deparse_pkg::edit_w-1:0] val_d;
    logic [deparse_pkg::n_act-1:0][deparse_pkg::len_w-1:0]  len_d;

    always_comb begin
        deparse_pkg::act_t               act;
        logic [deparse_pkg::edit_w-1:0]  raw;
        for (int a = 0; a < deparse_pkg::n_act; a++) begin
            act = entry[a];
            case (act.size)
                2'd1: begin
                    raw      = 48'(phv[deparse_pkg::phv_2b_pos + 16 * act.idx[1:0] +: 16]);
                    len_d[a] = 3'd2;
                end
                2'd2: begin
                    raw      = 48'(phv[deparse_pkg::phv_4b_pos + 32 * act.idx[1:0] +: 32]);
                    len_d[a] = 3'd4;
                end
                2'd3: begin
                    raw      = phv[deparse_pkg::phv_6b_pos + 48 * act.idx[1:0] +: 48];
                    len_d[a] = 3'd6;
                end
                default: begin
                    raw      = '0;
                    len_d[a] = '0;
                end
            endcase
            // byte reversal leaves the msb first, left-aligned
            for (int b = 0; b < deparse_pkg::max_bytes; b++) begin
                val_d[a][8*b +: 8] = raw[8*(deparse_pkg::max_bytes-1-b) +: 8];
            end
        end
    end

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            edit.edit_en    <= '0;
            edit.edit_valid <= 1'b0;
        end else begin
            edit.edit_valid <= entry_valid;
            if (entry_valid) begin
                for (int a = 0; a < deparse_pkg::n_act; a++) begin
                    edit.edit_en[a] <= entry[a].valid && entry[a].size != 2'd0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (entry_valid) begin
            edit.edit_val <= val_d;
            edit.edit_len <= len_d;
            for (int a = 0; a < deparse_pkg::n_act; a++) begin
                edit.edit_off[a] <= entry[a].off;
            end
        end
    end

endmodule

/* ctrl_pkg.sv */
package ctrl_pkg;

    localparam logic [2:0]  deparser_id = 3'b101;
    localparam logic [15:0] ctrl_flag   = 16'hf2f1;

    // header beat of a control packet
    typedef struct packed {
        logic [63:0]  rsvd_hi;
        logic [7:0]   start_idx;
        logic [7:0]   rsvd_idx;
        logic [7:0]   mod_id;
        logic [31:0]  rsvd_mid;
        logic [15:0]  flag;
        logic [119:0] rsvd_lo;
    } ctrl_hdr_t;

    // entry beats carry one table entry in the low bits
    typedef struct packed {
        logic [191:0]        rsvd;
        deparse_pkg::entry_t ent;
    } ctrl_ent_t;

    typedef union packed {
        ctrl_hdr_t hdr;
        ctrl_ent_t ent;
    } ctrl_beat_u;

endpackage

/* deparse_fsm.sv */
`timescale 1ns/10ps

module deparse_fsm (
    input  logic                              clk,
    input  logic                              aresetn,
    input  logic [deparse_pkg::data_w-1:0]    pkt_tdata,
    input  logic [deparse_pkg::keep_w-1:0]    pkt_tkeep,
    input  logic                              pkt_tlast,
    input  logic                              pkt_empty,
    input  logic [deparse_pkg::phv_w-1:0]     phv_data,
    input  logic                              phv_empty,
    input  logic [deparse_pkg::data_w-1:0]    merged_beat,
    input  logic                              out_ready,
    output logic                              pkt_rd_en,
    output logic                              phv_rd_en,
    output logic [deparse_pkg::data_w-1:0]    hdr_beat,
    output logic [deparse_pkg::phv_w-1:0]     phv_held,
    output logic [deparse_pkg::addr_w-1:0]    lookup_addr,
    output logic                              lookup_en,
    output logic                              entry_valid,
    output logic [deparse_pkg::data_w-1:0]    out_tdata,
    output logic [deparse_pkg::keep_w-1:0]    out_tkeep,
    output logic                              out_tvalid,
    output logic                              out_tlast
);

    typedef enum logic [1:0] {
        IDLE,
        WAIT,
        EMIT,
        PASS
    } state_t;

    state_t                               state;
    logic                                 capture;
    logic [deparse_pkg::lat_cnt_w-1:0]    wait_cnt;
    logic [deparse_pkg::keep_w-1:0]       hdr_keep;
    logic                                 hdr_last;

    assign capture   = state == IDLE && !pkt_empty && !phv_empty;
    assign phv_rd_en = capture;
    assign pkt_rd_en = capture || (state == PASS && out_tvalid && out_ready);

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            state       <= IDLE;
            wait_cnt    <= '0;
            lookup_en   <= 1'b0;
            entry_valid <= 1'b0;
        end else begin
            lookup_en   <= capture;
            entry_valid <= lookup_en;
            case (state)
                IDLE: begin
                    if (capture) begin
                        wait_cnt <= '0;
                        state    <= WAIT;
                    end
                end
                // table read, container select, merge
                WAIT: begin
                    if (wait_cnt == deparse_pkg::lat_cnt_max) begin
                        state <= EMIT;
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                EMIT: begin
                    if (out_ready) begin
                        state <= hdr_last ? IDLE : PASS;
                    end
                end
                PASS: begin
                    if (out_tvalid && out_ready && pkt_tlast) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            hdr_beat    <= pkt_tdata;
            hdr_keep    <= pkt_tkeep;
            hdr_last    <= pkt_tlast;
            phv_held    <= phv_data;
            lookup_addr <= pkt_tdata[deparse_pkg::vlan_pos + 4 +: deparse_pkg::addr_w];
        end
    end

    // merged header while emitting, fifo head afterwards
    always_comb begin
        out_tdata  = merged_beat;
        out_tkeep  = hdr_keep;
        out_tlast  = hdr_last;
        out_tvalid = state == EMIT;
        if (state == PASS) begin
            out_tdata  = pkt_tdata;
            out_tkeep  = pkt_tkeep;
            out_tlast  = pkt_tlast;
            out_tvalid = !pkt_empty;
        end
    end

endmodule

/* deparse_pkg.sv */
package deparse_pkg;

    // beat geometry
    localparam int data_w = 256;
    localparam int keep_w = data_w / 8;

    // phv layout, 2-byte group at bit 0
    localparam int n_cont     = 4;
    localparam int phv_2b_pos = 0;
    localparam int phv_4b_pos = phv_2b_pos + n_cont * 16;
    localparam int phv_6b_pos = phv_4b_pos + n_cont * 32;
    localparam int phv_w      = phv_6b_pos + n_cont * 48;

    // action table
    localparam int n_act   = 4;
    localparam int n_entry = 16;
    localparam int addr_w  = 4;

    // vlan id start in the first beat
    localparam int vlan_pos = 116;

    // per-action edit fields
    localparam int edit_w    = 48;
    localparam int max_bytes = edit_w / 8;
    localparam int len_w     = 3;
    localparam int off_w     = 6;

    // capture to merged beat
    localparam int edit_lat  = 3;
    localparam int lat_cnt_w = $clog2(edit_lat + 1);
    localparam logic [lat_cnt_w-1:0] lat_cnt_max = lat_cnt_w'(edit_lat);

    typedef struct packed {
        logic [3:0]       rsvd;
        logic [off_w-1:0] off;
        logic [1:0]       size;
        logic [2:0]       idx;
        logic             valid;
    } act_t;

    // action 0 sits in the low bits
    typedef act_t [n_act-1:0] entry_t;

endpackage

/* deparser.sv */
`timescale 1ns/10ps

module deparser (
    input  logic                              clk,
    input  logic                              aresetn,
    input  logic [deparse_pkg::data_w-1:0]    pkt_tdata,
    input  logic [deparse_pkg::keep_w-1:0]    pkt_tkeep,
    input  logic                              pkt_tlast,
    input  logic                              pkt_empty,
    output logic                              pkt_rd_en,
    input  logic [deparse_pkg::phv_w-1:0]     phv_data,
    input  logic                              phv_empty,
    output logic                              phv_rd_en,
    output logic [deparse_pkg::data_w-1:0]    out_tdata,
    output logic [deparse_pkg::keep_w-1:0]    out_tkeep,
    output logic                              out_tvalid,
    output logic                              out_tlast,
    input  logic                              out_ready,
    input  logic [deparse_pkg::data_w-1:0]    c_tdata,
    input  logic                              c_tvalid,
    input  logic                              c_tlast
);

    logic [deparse_pkg::addr_w-1:0]  lookup_addr;
    logic                            lookup_en;
    logic                            entry_valid;
    deparse_pkg::entry_t             entry;
    logic [deparse_pkg::data_w-1:0]  hdr_beat;
    logic [deparse_pkg::data_w-1:0]  merged_beat;
    logic [deparse_pkg::phv_w-1:0]   phv_held;

    edit_if edit_bus ();

    action_table i_action_table (
        .clk         (clk),
        .aresetn     (aresetn),
        .c_tdata     (c_tdata),
        .c_tvalid    (c_tvalid),
        .c_tlast     (c_tlast),
        .lookup_addr (lookup_addr),
        .lookup_en   (lookup_en),
        .entry       (entry)
    );

    container_select i_container_select (
        .clk         (clk),
        .aresetn     (aresetn),
        .entry       (entry),
        .entry_valid (entry_valid),
        .phv         (phv_held),
        .edit        (edit_bus.src)
    );

    header_merge i_header_merge (
        .clk         (clk),
        .aresetn     (aresetn),
        .edit        (edit_bus.dst),
        .hdr_beat    (hdr_beat),
        .merged_beat (merged_beat)
    );

    deparse_fsm i_deparse_fsm (
        .clk         (clk),
        .aresetn     (aresetn),
        .pkt_tdata   (pkt_tdata),
        .pkt_tkeep   (pkt_tkeep),
        .pkt_tlast   (pkt_tlast),
        .pkt_empty   (pkt_empty),
        .phv_data    (phv_data),
        .phv_empty   (phv_empty),
        .merged_beat (merged_beat),
        .out_ready   (out_ready),
        .pkt_rd_en   (pkt_rd_en),
        .phv_rd_en   (phv_rd_en),
        .hdr_beat    (hdr_beat),
        .phv_held    (phv_held),
        .lookup_addr (lookup_addr),
        .lookup_en   (lookup_en),
        .entry_valid (entry_valid),
        .out_tdata   (out_tdata),
        .out_tkeep   (out_tkeep),
        .out_tvalid  (out_tvalid),
        .out_tlast   (out_tlast)
    );

endmodule

/* deparser_cases.txt */
# w start mod_id flag | a tlast act3 act2 act1 act0 | h phv (applies to later packets)
# p beats first_beat, then e expected_first_beat; values in hex, beats and tlast decimal
w 1 05 f2f1
a 0 0000 0231 0123 0015
a 0 00d7 0193 0125 00b7
a 1 0791 06f5 0083 0020
h 633132333435622122232425611112131415600102030405433132334221222341111213400102032334222321122001
p 3 21300000abaaa9a8a7a6a5a4a3a2a1a0
e 213005040302016013121141a3a22322
p 4 22300000abaaa9a8a7a6a5a4a3a2a1a0
e 22300000abaaa9a8122121342363a1a0
p 2 23300000abaaa9a8a7a6a5a4a3a2a1a0
e 0120000000000000000000000000000023300000abaaa9a8a7a6a5a4a3a2a1a0
w 1 04 f2f1
a 1 0000 0000 0000 0011
w 1 05 f2f0
a 1 0000 0000 0000 0011
p 5 21300000abaaa9a8a7a6a5a4a3a2a1a0
e 213005040302016013121141a3a22322
p 1 22300000abaaa9a8a7a6a5a4a3a2a1a0
e 22300000abaaa9a8122121342363a1a0
p 3 23300000abaaa9a8a7a6a5a4a3a2a1a0
e 0120000000000000000000000000000023300000abaaa9a8a7a6a5a4a3a2a1a0

/* deparser_sva.sv */
`timescale 1ns/10ps

module deparser_sva (
    input logic                              clk,
    input logic                              aresetn,
    input logic [deparse_pkg::data_w-1:0]    out_tdata,
    input logic                              out_tvalid,
    input logic                              out_ready,
    input logic                              pkt_rd_en,
    input logic                              pkt_empty,
    input logic                              phv_rd_en
);

    // a stalled beat stays put until taken
    property hold_while_stalled;
        @(posedge clk) disable iff (!aresetn)
            out_tvalid && !out_ready |=> out_tvalid && $stable(out_tdata);
    endproperty

    property no_pop_when_empty;
        @(posedge clk) disable iff (!aresetn)
            pkt_empty |-> !pkt_rd_en;
    endproperty

    // valid goes high edit_lat + 1 clocks after capture, first sampled one edge later
    property header_latency;
        @(posedge clk) disable iff (!aresetn)
            phv_rd_en |-> ##(deparse_pkg::edit_lat + 2) $rose(out_tvalid);
    endproperty

    a_hold: assert property (hold_while_stalled)
        else $error("out_tdata changed or valid dropped while stalled");
    a_pop: assert property (no_pop_when_empty)
        else $error("pkt_rd_en high with an empty packet fifo");
    a_lat: assert property (header_latency)
        else $error("header beat not valid at the expected cycle after capture");

endmodule

bind deparser deparser_sva i_deparser_sva (
    .clk        (clk),
    .aresetn    (aresetn),
    .out_tdata  (out_tdata),
    .out_tvalid (out_tvalid),
    .out_ready  (out_ready),
    .pkt_rd_en  (pkt_rd_en),
    .pkt_empty  (pkt_empty),
    .phv_rd_en  (phv_rd_en)
);

/* edit_if.sv */
`timescale 1ns/10ps

interface edit_if;

    // one lane per action
    logic [deparse_pkg::n_act-1:0][deparse_pkg::edit_w-1:0] edit_val;
    logic [deparse_pkg::n_act-1:0][deparse_pkg::len_w-1:0]  edit_len;
    logic [deparse_pkg::n_act-1:0][deparse_pkg::off_w-1:0]  edit_off;
    logic [deparse_pkg::n_act-1:0]                          edit_en;
    logic                                                   edit_valid;

    modport src (
        output edit_val,
        output edit_len,
        output edit_off,
        output edit_en,
        output edit_valid
    );

    modport dst (
        input edit_val,
        input edit_len,
        input edit_off,
        input edit_en,
        input edit_valid
    );

endinterface

/* header_merge.sv */
`timescale 1ns/10ps

module header_merge (
    input  logic                              clk,
    input  logic                              aresetn,
    edit_if.dst                               edit,
    input  logic [deparse_pkg::data_w-1:0]    hdr_beat,
    output logic [deparse_pkg::data_w-1:0]    merged_beat
);

    logic [deparse_pkg::data_w-1:0] merged_d;

    // later actions overwrite earlier ones
    always_comb begin
        int off;
        int len;
        merged_d = hdr_beat;
        for (int a = 0; a < deparse_pkg::n_act; a++) begin
            off = int'(edit.edit_off[a]);
            len = int'(edit.edit_len[a]);
            // drop edits that run past the beat
            if (edit.edit_en[a] && off + len <= deparse_pkg::keep_w) begin
                for (int b = 0; b < deparse_pkg::max_bytes; b++) begin
                    if (b < len) begin
                        merged_d[8*(off+b) +: 8] =
                            edit.edit_val[a][8*(deparse_pkg::max_bytes-len+b) +: 8];
                    end
                end
            end
        end
    end

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            merged_beat <= '0;
        end else if (edit.edit_valid) begin
            merged_beat <= merged_d;
        end
    end

endmodule

/* project.f */
deparse_pkg.sv
ctrl_pkg.sv
edit_if.sv
action_table.sv
container_select.sv
header_merge.sv
deparse_fsm.sv
deparser.sv
deparser_sva.sv
tb_deparser.sv

/* run.sh */
#!/bin/sh
# compile and run the deparser testbench with verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f project.f --top-module tb_deparser
out=$(./obj_dir/Vtb_deparser)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx 'NO ERRORS'

/* tb_deparser.sv */
`timescale 1ns/10ps

module tb_deparser;

    localparam int dw = deparse_pkg::data_w;
    localparam int kw = deparse_pkg::keep_w;
    localparam int pw = deparse_pkg::phv_w;
    localparam int drain_cycles = deparse_pkg::edit_lat + 4;

    logic          clk;
    logic          aresetn;
    logic [dw-1:0] pkt_tdata;
    logic [kw-1:0] pkt_tkeep;
    logic          pkt_tlast;
    logic          pkt_empty;
    logic          pkt_rd_en;
    logic [pw-1:0] phv_data;
    logic          phv_empty;
    logic          phv_rd_en;
    logic [dw-1:0] out_tdata;
    logic [kw-1:0] out_tkeep;
    logic          out_tvalid;
    logic          out_tlast;
    logic          out_ready;
    logic [dw-1:0] c_tdata;
    logic          c_tvalid;
    logic          c_tlast;

    // fifo entries and received beats as {last, keep, data}
    logic [dw+kw:0] src_q[$];
    logic [dw+kw:0] pkt_q[$];
    logic [pw-1:0]  phv_q[$];
    logic [dw+kw:0] rx_q[$];

    logic [dw-1:0]  ctl_beat;
    logic           ctl_valid;
    logic           ctl_last;
    logic [31:0]    lcg_state = 32'h126e_bf88;
    int             errors;
    int             checks;
    int             wd_cycles;

    deparser i_deparser (
        .clk        (clk),
        .aresetn    (aresetn),
        .pkt_tdata  (pkt_tdata),
        .pkt_tkeep  (pkt_tkeep),
        .pkt_tlast  (pkt_tlast),
        .pkt_empty  (pkt_empty),
        .pkt_rd_en  (pkt_rd_en),
        .phv_data   (phv_data),
        .phv_empty  (phv_empty),
        .phv_rd_en  (phv_rd_en),
        .out_tdata  (out_tdata),
        .out_tkeep  (out_tkeep),
        .out_tvalid (out_tvalid),
        .out_tlast  (out_tlast),
        .out_ready  (out_ready),
        .c_tdata    (c_tdata),
        .c_tvalid   (c_tvalid),
        .c_tlast    (c_tlast)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_val(input logic [dw-1:0] got, input logic [dw-1:0] exp,
                             input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0d ns: %s, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    // drive on the falling edge, sample shortly before the rising edge
    task automatic step();
        logic [31:0] r;
        @(negedge clk);
        r = next_rand();
        out_ready = r[31] | r[30];
        // beats reach the packet fifo with random gaps
        if (r[29] && src_q.size() > 0) begin
            pkt_q.push_back(src_q.pop_front());
        end
        pkt_empty = pkt_q.size() == 0;
        phv_empty = phv_q.size() == 0;
        {pkt_tlast, pkt_tkeep, pkt_tdata} = pkt_empty ? '0 : pkt_q[0];
        phv_data = phv_empty ? '0 : phv_q[0];
        c_tvalid = ctl_valid;
        c_tdata  = ctl_valid ? ctl_beat : '0;
        c_tlast  = ctl_valid & ctl_last;
        #40;
        if (pkt_rd_en && pkt_q.size() > 0) begin
            pkt_q.delete(0);
        end
        if (phv_rd_en && phv_q.size() > 0) begin
            phv_q.delete(0);
        end
        if (out_tvalid && out_ready) begin
            rx_q.push_back({out_tlast, out_tkeep, out_tdata});
        end
    endtask

    task automatic send_ctrl(input logic [dw-1:0] beat, input logic last);
        ctl_valid = 1'b1;
        ctl_beat  = beat;
        ctl_last  = last;
        step();
        ctl_valid = 1'b0;
        // table write lands one cycle later
        if (last) begin
            step();
        end
    endtask

    task automatic run_packet(input int nb, input logic [dw-1:0] first,
                              input logic [dw-1:0] exp_first, input logic [pw-1:0] phv);
        logic [dw+kw:0] exp_q[$];
        logic [dw-1:0]  data;
        logic [kw-1:0]  keep;
        logic           last;
        for (int i = 0; i < nb; i++) begin
            data = first;
            if (i > 0) begin
                for (int w = 0; w < dw / 32; w++) begin
                    data[32*w +: 32] = next_rand();
                end
            end
            last = i == nb - 1;
            keep = last ? next_rand() : '1;
            src_q.push_back({last, keep, data});
            exp_q.push_back({last, keep, (i == 0) ? exp_first : data});
        end
        phv_q.push_back(phv);
        while (rx_q.size() < nb) begin
            step();
        end
        // quiet window, no extra beats may follow
        repeat (drain_cycles) step();
        check_val(rx_q.size(), nb, "number of emitted beats");
        check_val(pkt_q.size(), 0, "beats left in packet fifo");
        check_val(phv_q.size(), 0, "entries left in phv fifo");
        for (int i = 0; i < nb && i < rx_q.size(); i++) begin
            check_val(rx_q[i][dw-1:0], exp_q[i][dw-1:0], $sformatf("beat %0d tdata", i));
            check_val(rx_q[i][dw+kw-1:dw], exp_q[i][dw+kw-1:dw],
                      $sformatf("beat %0d tkeep", i));
            check_val(rx_q[i][dw+kw], exp_q[i][dw+kw], $sformatf("beat %0d tlast", i));
        end
        rx_q.delete();
    endtask

    initial begin
        string                lines[$];
        string                line;
        byte                  tag;
        int                   fd;
        int                   nb;
        int                   last;
        int                   n_tests;
        int                   n_ctrl;
        int                   max_beats;
        int                   test_no;
        int                   errs_before;
        logic [7:0]           st;
        logic [7:0]           mid;
        logic [15:0]          flag;
        logic [15:0]          a0;
        logic [15:0]          a1;
        logic [15:0]          a2;
        logic [15:0]          a3;
        logic [dw-1:0]        first;
        logic [dw-1:0]        expd;
        logic [pw-1:0]        phv;
        ctrl_pkg::ctrl_beat_u cb;
        aresetn   = 1'b0;
        pkt_tdata = '0;
        pkt_tkeep = '0;
        pkt_tlast = 1'b0;
        pkt_empty = 1'b1;
        phv_data  = '0;
        phv_empty = 1'b1;
        out_ready = 1'b0;
        c_tdata   = '0;
        c_tvalid  = 1'b0;
        c_tlast   = 1'b0;
        ctl_valid = 1'b0;
        ctl_beat  = '0;
        ctl_last  = 1'b0;
        n_tests   = 0;
        n_ctrl    = 0;
        max_beats = 1;
        test_no   = 0;
        phv       = '0;
        first     = '0;
        nb        = 1;
        fd = $fopen("deparser_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open deparser_cases.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                if ($fgets(line, fd) > 0 && line.len() > 1 && line.getc(0) != "#") begin
                    lines.push_back(line);
                    tag = line.getc(0);
                    if (tag == "p") begin
                        void'($sscanf(line, "p %d", nb));
                        n_tests++;
                        if (nb > max_beats) begin
                            max_beats = nb;
                        end
                    end else if (tag == "w" || tag == "a") begin
                        n_ctrl++;
                    end
                end
            end
            $fclose(fd);
            wd_cycles = n_tests * max_beats * 20 + n_ctrl * 4 + 20;
        end
        repeat (8) @(negedge clk);
        aresetn = 1'b1;
        foreach (lines[i]) begin
            line = lines[i];
            tag = line.getc(0);
            case (tag)
                "w": begin
                    void'($sscanf(line, "w %h %h %h", st, mid, flag));
                    cb = '0;
                    cb.hdr.start_idx = st;
                    cb.hdr.mod_id    = mid;
                    cb.hdr.flag      = flag;
                    send_ctrl(cb, 1'b0);
                end
                "a": begin
                    void'($sscanf(line, "a %d %h %h %h %h", last, a3, a2, a1, a0));
                    cb = '0;
                    cb.ent.ent[0] = deparse_pkg::act_t'(a0);
                    cb.ent.ent[1] = deparse_pkg::act_t'(a1);
                    cb.ent.ent[2] = deparse_pkg::act_t'(a2);
                    cb.ent.ent[3] = deparse_pkg::act_t'(a3);
                    send_ctrl(cb, last != 0);
                end
                "h": void'($sscanf(line, "h %h", phv));
                "p": void'($sscanf(line, "p %d %h", nb, first));
                "e": begin
                    void'($sscanf(line, "e %h", expd));
                    errs_before = errors;
                    test_no++;
                    run_packet(nb, first, expd, phv);
                    $display("test %0d, %0d beats: %s", test_no, nb,
                             (errors == errs_before) ? "ok" : "mismatch");
                end
                default: begin
                    $display("unknown record in deparser_cases.txt: %s", line);
                    errors++;
                end
            endcase
        end
        $display("%0d tests, %0d checks, %0d errors", test_no, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin
        wait (wd_cycles > 0);
        repeat (wd_cycles) @(posedge clk);
        $display("timeout: the DUT did not finish the cases within %0d cycles", wd_cycles);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule
